/* sim.f */
rtl/l0_cfg_pkg.sv
rtl/l0_bus_pkg.sv
rtl/l0_tag_store.sv
rtl/l0_line_data.sv
rtl/l0_refill_ctrl.sv
rtl/l0_fetch_cache.sv
testbench/tb_refill_memory.sv
testbench/tb_l0_fetch_cache.sv

/* run_sim.sh */
#!/bin/sh
# compile the L0 fetch cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module tb_l0_fetch_cache -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/Vtb_l0_fetch_cache > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

/* testbench/tb_l0_fetch_cache.sv */
/*
  Testbench of the L0 fetch cache. Random word fetches over twelve lines and
  occasional flushes are checked against a cache model kept here, while a
  behavioral memory serves the refill port.
*/

`timescale 1ns/1ps

module tb_l0_fetch_cache;

  localparam int          LINES       = 4;
  localparam int          FETCHES     = 400;
  localparam int          TIMEOUT     = 200;
  localparam int          DRIVE_DELAY = 1;
  localparam logic [31:0] SEED        = 32'hb2efd3b3;
  localparam logic [31:0] DATA_KEY    = 32'h5a5a_0000;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    flush_i;
  l0_bus_pkg::fetch_req_t  in_req_i;
  logic                    in_valid_i;
  logic [31:0]             in_data_o;
  logic                    in_ready_o;
  logic                    in_error_o;
  l0_bus_pkg::refill_req_t out_req_o;
  logic                    out_req_valid_o;
  logic                    out_req_ready_i;
  l0_bus_pkg::refill_rsp_t out_rsp_i;
  logic                    out_rsp_valid_i;

  // cache model
  logic [l0_cfg_pkg::TAG_W-1:0] model_tag [LINES];
  logic [LINES-1:0]             model_valid;
  int                           model_rr;

  integer      seed;
  int          value_errors  = 0;
  int          other_errors  = 0;
  int          req_count     = 0;
  int          miss_count    = 0;
  int          hit_count     = 0;
  logic        timed_out     = 1'b0;
  logic        stall_seen    = 1'b0;
  logic [31:0] stall_addr    = '0;
  logic [31:0] last_req_addr = '0;

  l0_fetch_cache #(
    .LINE_COUNT(LINES)
  ) uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .in_req_i       (in_req_i),
    .in_valid_i     (in_valid_i),
    .in_data_o      (in_data_o),
    .in_ready_o     (in_ready_o),
    .in_error_o     (in_error_o),
    .out_req_o      (out_req_o),
    .out_req_valid_o(out_req_valid_o),
    .out_req_ready_i(out_req_ready_i),
    .out_rsp_i      (out_rsp_i),
    .out_rsp_valid_i(out_rsp_valid_i)
  );

  tb_refill_memory #(
    .SEED       (SEED ^ 32'h0000_ffff),
    .DRIVE_DELAY(DRIVE_DELAY)
  ) u_memory (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (out_req_o),
    .req_valid_i(out_req_valid_o),
    .req_ready_o(out_req_ready_i),
    .rsp_o      (out_rsp_i),
    .rsp_valid_o(out_rsp_valid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // checks and model helpers
  // --------------------------------------------------

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  function automatic logic model_hit(input logic [l0_cfg_pkg::TAG_W-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < LINES; i++) begin
      if (model_valid[i] && model_tag[i] == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // ten plain lines in a row, two error lines further away
  function automatic logic [31:0] line_base(input int idx);
    if (idx < 10) begin
      return 32'h0000_1000 + 32'(idx) * 32'h10;
    end
    return 32'h0000_13f0 + 32'(idx - 10) * 32'h1000;
  endfunction

  // --------------------------------------------------
  // refill request monitor
  // --------------------------------------------------

  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (stall_seen) begin
          check_flag("out_req_valid_o", out_req_valid_o, 1'b1);
          check_word("out_req_o.addr", out_req_o.addr, stall_addr);
        end
        if (out_req_valid_o && out_req_ready_i) begin
          req_count++;
          last_req_addr = out_req_o.addr;
        end
        stall_seen = out_req_valid_o && !out_req_ready_i;
        stall_addr = out_req_o.addr;
      end
    end
  end

  // --------------------------------------------------
  // one fetch, started right after a clock edge
  // --------------------------------------------------

  task automatic run_fetch(input logic [31:0] addr);
    logic [l0_cfg_pkg::TAG_W-1:0] tag;
    logic                         bad_line;
    int                           line;
    int                           req_before;
    int                           cycles;
    tag           = addr[31:l0_cfg_pkg::LINE_ALIGN];
    bad_line      = (addr[9:4] == 6'h3f);
    req_before    = req_count;
    in_req_i.addr = addr;
    in_valid_i    = 1'b1;
    if (model_hit(tag)) begin
      hit_count++;
      @(negedge clk_i);
      check_flag("in_ready_o", in_ready_o, 1'b1);
      check_flag("in_error_o", in_error_o, 1'b0);
      check_flag("out_req_valid_o", out_req_valid_o, 1'b0);
      check_word("in_data_o", in_data_o, addr ^ DATA_KEY);
    end else begin
      // victim is taken round-robin, its old contents are gone at once
      line              = model_rr;
      model_tag[line]   = tag;
      model_valid[line] = 1'b0;
      model_rr          = (model_rr + 1) % LINES;
      miss_count++;
      @(negedge clk_i);
      check_flag("in_ready_o", in_ready_o, 1'b0);
      cycles = 0;
      while (!in_ready_o && cycles < TIMEOUT) begin
        @(negedge clk_i);
        cycles++;
      end
      assert (in_ready_o) else begin
        $display("timeout: fetch of address %h not completed after %0d cycles", addr, TIMEOUT);
        other_errors++;
        timed_out = 1'b1;
      end
      if (in_ready_o) begin
        check_flag("in_error_o", in_error_o, bad_line);
        check_word("refill request count", req_count, req_before + 1);
        check_word("out_req_o.addr", last_req_addr, {addr[31:4], 4'h0});
        if (!bad_line) begin
          check_word("in_data_o", in_data_o, addr ^ DATA_KEY);
          model_valid[line] = 1'b1;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    int          idx;
    int          word;
    int          gap;
    logic [31:0] addr;
    seed        = SEED;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_req_i    = '0;
    model_valid = '0;
    model_rr    = 0;
    repeat (16) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;

    for (int n = 0; n < FETCHES && !timed_out; n++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      in_valid_i = 1'b0;
      gap = {$random(seed)} % 3;
      for (int g = 0; g < gap; g++) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
      end
      if ({$random(seed)} % 12 == 0) begin
        flush_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DELAY;
        flush_i     = 1'b0;
        model_valid = '0;
      end
      idx  = {$random(seed)} % 12;
      word = {$random(seed)} % 4;
      addr = line_base(idx) + 32'(word) * 32'h4;
      run_fetch(addr);
    end

    @(posedge clk_i);
    #DRIVE_DELAY;
    in_valid_i = 1'b0;
    check_word("refill request count", req_count, miss_count);

    $display("summary: %0d hits, %0d misses, %0d value errors, %0d other errors",
             hit_count, miss_count, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* testbench/tb_refill_memory.sv */
/*
  Behavioral next-level memory for the L0 fetch cache testbench. Accepts one
  refill request at a time with random back-pressure and answers it with a
  computed line after a random delay.
*/

`timescale 1ns/1ps

module tb_refill_memory #(
  parameter logic [31:0] SEED        = 32'h0000_0001,
  parameter int          DRIVE_DELAY = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  l0_bus_pkg::refill_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output l0_bus_pkg::refill_rsp_t rsp_o,
  output logic                    rsp_valid_o
);

  integer      seed;
  logic        fire;
  logic        busy;
  int          wait_cnt;
  logic [31:0] req_addr;
  logic [31:0] line_addr;

  // each word is its byte address xor a fixed key, bits 9:4 all ones mark an error line
  function automatic l0_bus_pkg::refill_rsp_t build_response(input logic [31:0] addr);
    l0_bus_pkg::refill_rsp_t rsp;
    rsp.error = (addr[9:4] == 6'h3f);
    for (int k = 0; k < 4; k++) begin
      rsp.data[k*32 +: 32] = (addr + 32'(4 * k)) ^ 32'h5a5a_0000;
    end
    return rsp;
  endfunction

  initial begin
    seed        = SEED;
    busy        = 1'b0;
    wait_cnt    = 0;
    line_addr   = '0;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    forever begin
      // handshake is sampled mid cycle, acted on after the next edge
      @(negedge clk_i);
      fire     = req_valid_i && req_ready_o;
      req_addr = req_i.addr;
      @(posedge clk_i);
      #DRIVE_DELAY;
      rsp_valid_o = 1'b0;
      if (!rst_ni) begin
        busy        = 1'b0;
        req_ready_o = 1'b0;
      end else if (fire) begin
        busy        = 1'b1;
        line_addr   = req_addr;
        wait_cnt    = {$random(seed)} % 6;
        req_ready_o = 1'b0;
      end else if (busy) begin
        if (wait_cnt == 0) begin
          rsp_o       = build_response(line_addr);
          rsp_valid_o = 1'b1;
          busy        = 1'b0;
        end else begin
          wait_cnt--;
        end
      end else begin
        // ready low roughly one cycle in four
        req_ready_o = ({$random(seed)} % 4) != 0;
      end
    end
  end

endmodule

/* rtl/l0_fetch_cache.sv */
/*
  Top level of the L0 instruction fetch cache. Connects the tag store, the
  line data array and the refill controller between the fetch port and the
  refill port toward the next level.
*/

`timescale 1ns/1ps

module l0_fetch_cache #(
  parameter int unsigned LINE_COUNT = l0_cfg_pkg::DEFAULT_LINE_COUNT
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,

  // fetch port
  input  l0_bus_pkg::fetch_req_t          in_req_i,
  input  logic                            in_valid_i,
  output logic [l0_cfg_pkg::FETCH_W-1:0]  in_data_o,
  output logic                            in_ready_o,
  output logic                            in_error_o,

  // refill port
  output l0_bus_pkg::refill_req_t         out_req_o,
  output logic                            out_req_valid_o,
  input  logic                            out_req_ready_i,
  input  l0_bus_pkg::refill_rsp_t         out_rsp_i,
  input  logic                            out_rsp_valid_i
);

  logic [LINE_COUNT-1:0] hit;
  logic [LINE_COUNT-1:0] victim;
  logic [LINE_COUNT-1:0] validate;
  logic                  alloc;

  // --------------------------------------------------
  // tags
  // --------------------------------------------------

  l0_tag_store #(
    .LINE_COUNT(LINE_COUNT)
  ) u_tag_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_tag_i(in_req_i.addr[l0_cfg_pkg::ADDR_W-1:l0_cfg_pkg::LINE_ALIGN]),
    .alloc_i     (alloc),
    .validate_i  (validate),
    .flush_i     (flush_i),
    .hit_o       (hit),
    .victim_o    (victim)
  );

  // --------------------------------------------------
  // data
  // --------------------------------------------------

  l0_line_data #(
    .LINE_COUNT(LINE_COUNT)
  ) u_line_data (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .line_i    (out_rsp_i.data),
    .validate_i(validate),
    .hit_i     (hit),
    .word_sel_i(in_req_i.addr[l0_cfg_pkg::LINE_ALIGN-1:l0_cfg_pkg::FETCH_ALIGN]),
    .data_o    (in_data_o)
  );

  // --------------------------------------------------
  // miss handling
  // --------------------------------------------------

  l0_refill_ctrl #(
    .LINE_COUNT(LINE_COUNT)
  ) u_refill_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_valid_i  (in_valid_i),
    .fetch_addr_i   (in_req_i),
    .hit_i          (hit),
    .victim_i       (victim),
    .alloc_o        (alloc),
    .validate_o     (validate),
    .out_req_o      (out_req_o),
    .out_req_valid_o(out_req_valid_o),
    .out_req_ready_i(out_req_ready_i),
    .out_rsp_i      (out_rsp_i),
    .out_rsp_valid_i(out_rsp_valid_i),
    .fetch_ready_o  (in_ready_o),
    .fetch_error_o  (in_error_o)
  );

endmodule

/* rtl/l0_refill_ctrl.sv */
/*
  Miss handling of the L0 fetch cache. Detects a miss, allocates the victim,
  issues one line aligned refill request and on the response either
  validates the line or completes the waiting fetch with an error.
*/

`timescale 1ns/1ps

module l0_refill_ctrl #(
  parameter int unsigned LINE_COUNT = l0_cfg_pkg::DEFAULT_LINE_COUNT
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_valid_i,
  input  l0_bus_pkg::fetch_req_t  fetch_addr_i,
  input  logic [LINE_COUNT-1:0]   hit_i,
  input  logic [LINE_COUNT-1:0]   victim_i,
  output logic                    alloc_o,
  output logic [LINE_COUNT-1:0]   validate_o,
  output l0_bus_pkg::refill_req_t out_req_o,
  output logic                    out_req_valid_o,
  input  logic                    out_req_ready_i,
  input  l0_bus_pkg::refill_rsp_t out_rsp_i,
  input  logic                    out_rsp_valid_i,
  output logic                    fetch_ready_o,
  output logic                    fetch_error_o
);

  localparam int unsigned OFFS_W = l0_cfg_pkg::LINE_ALIGN;
  localparam int unsigned ADDR_W = l0_cfg_pkg::ADDR_W;

  logic                    pending_q;
  logic                    req_valid_q;
  l0_bus_pkg::refill_req_t req_q;
  logic [LINE_COUNT-1:0]   line_q;
  logic                    miss;
  logic                    rsp_done;
  logic                    rsp_good;

  // --------------------------------------------------
  // miss detection
  // --------------------------------------------------

  // only one refill in flight, the waiting fetch simply stalls
  assign miss    = fetch_valid_i && !(|hit_i) && !pending_q;
  assign alloc_o = miss;

  assign rsp_done = out_rsp_valid_i && pending_q;
  assign rsp_good = rsp_done && !out_rsp_i.error;

  // --------------------------------------------------
  // control state
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      req_valid_q <= 1'b0;
    end else begin
      if (miss) begin
        pending_q <= 1'b1;
      end else if (rsp_done) begin
        pending_q <= 1'b0;
      end
      if (miss) begin
        req_valid_q <= 1'b1;
      end else if (out_req_ready_i) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  // request address and victim line, captured with the miss
  always_ff @(posedge clk_i) begin
    if (miss) begin
      req_q.addr <= {fetch_addr_i.addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
      line_q     <= victim_i;
    end
  end

  assign out_req_o       = req_q;
  assign out_req_valid_o = req_valid_q;

  // --------------------------------------------------
  // response handling
  // --------------------------------------------------

  assign validate_o = {LINE_COUNT{rsp_good}} & line_q;

  // error line stays invalid, so the fetch is released here instead
  assign fetch_error_o = rsp_done && out_rsp_i.error;
  assign fetch_ready_o = (|hit_i) || fetch_error_o;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  req_stable_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_req_valid_o && !out_req_ready_i |=> out_req_valid_o && $stable(out_req_o)
  );

  // a response is only legal once its request has left
  rsp_outstanding_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_rsp_valid_i |-> pending_q && !out_req_valid_o
  );

endmodule

/* rtl/l0_line_data.sv */
/*
  Line data array of the L0 fetch cache. A refill line is written into the
  validated entry; the hit line and the addressed word within it are
  selected combinationally toward the fetch port.
*/

`timescale 1ns/1ps

module l0_line_data #(
  parameter int unsigned LINE_COUNT = l0_cfg_pkg::DEFAULT_LINE_COUNT
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [l0_cfg_pkg::LINE_W-1:0]                          line_i,
  input  logic [LINE_COUNT-1:0]                                  validate_i,
  input  logic [LINE_COUNT-1:0]                                  hit_i,
  input  logic [l0_cfg_pkg::LINE_ALIGN-l0_cfg_pkg::FETCH_ALIGN-1:0] word_sel_i,
  output logic [l0_cfg_pkg::FETCH_W-1:0]                         data_o
);

  localparam int unsigned WORDS = l0_cfg_pkg::LINE_W / l0_cfg_pkg::FETCH_W;

  logic [l0_cfg_pkg::LINE_W-1:0]            line_q [LINE_COUNT];
  logic [l0_cfg_pkg::LINE_W-1:0]            hit_line;
  logic [WORDS-1:0][l0_cfg_pkg::FETCH_W-1:0] hit_words;

  // --------------------------------------------------
  // write port
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        line_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        if (validate_i[i]) begin
          line_q[i] <= line_i;
        end
      end
    end
  end

  // --------------------------------------------------
  // read port
  // --------------------------------------------------

  // and-or mux, hit vector is one-hot or zero
  always_comb begin
    hit_line = '0;
    for (int i = 0; i < LINE_COUNT; i++) begin
      hit_line |= {l0_cfg_pkg::LINE_W{hit_i[i]}} & line_q[i];
    end
  end

  // word 0 sits in the low bits of the line
  assign hit_words = hit_line;
  assign data_o    = hit_words[word_sel_i];

endmodule

/* rtl/l0_tag_store.sv */
/*
  Tag and valid array of the fully associative L0 fetch cache. Compares the
  lookup tag against every line, picks refill victims round-robin and applies
  allocate, validate and flush at the clock edge.
*/

`timescale 1ns/1ps

module l0_tag_store #(
  parameter int unsigned LINE_COUNT = l0_cfg_pkg::DEFAULT_LINE_COUNT
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [l0_cfg_pkg::TAG_W-1:0] lookup_tag_i,
  input  logic                         alloc_i,
  input  logic [LINE_COUNT-1:0]        validate_i,
  input  logic                         flush_i,
  output logic [LINE_COUNT-1:0]        hit_o,
  output logic [LINE_COUNT-1:0]        victim_o
);

  localparam int unsigned PTR_W = $clog2(LINE_COUNT);

  logic [l0_cfg_pkg::TAG_W-1:0] tag_q [LINE_COUNT];
  logic [LINE_COUNT-1:0]        valid_q;
  logic [LINE_COUNT-1:0]        alloc_mask;
  logic [PTR_W-1:0]             rr_q;

  // --------------------------------------------------
  // lookup
  // --------------------------------------------------

  // every valid line is compared in parallel
  for (genvar i = 0; i < LINE_COUNT; i++) begin : gen_cmp
    assign hit_o[i] = valid_q[i] && (tag_q[i] == lookup_tag_i);
  end

  // --------------------------------------------------
  // victim choice
  // --------------------------------------------------

  // pointer walks the lines in order and a flush leaves it alone
  assign victim_o   = {{(LINE_COUNT-1){1'b0}}, 1'b1} << rr_q;
  assign alloc_mask = {LINE_COUNT{alloc_i}} & victim_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (alloc_i) begin
      // wraps by itself as the line count is a power of two
      rr_q <= rr_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // tag and valid update
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < LINE_COUNT; i++) begin
      if (alloc_mask[i]) begin
        tag_q[i] <= lookup_tag_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      // flush beats a validate in the same cycle
      valid_q <= '0;
    end else begin
      // newly allocated line stays invalid until its refill returns
      valid_q <= (valid_q | validate_i) & ~alloc_mask;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // holds only while allocation happens on misses alone
  hit_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_o)
  );

  // a tag already present would be duplicated by an allocation on a hit
  alloc_on_miss_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    alloc_i |-> !(|hit_o)
  );

endmodule

/* rtl/l0_bus_pkg.sv */
/*
  Payload structs of the L0 fetch cache ports: the fetch request from the
  core side and the refill request and response toward the next level.
*/

package l0_bus_pkg;

  // --------------------------------------------------
  // fetch port
  // --------------------------------------------------

  // byte address of the instruction word to fetch
  typedef struct packed {
    logic [l0_cfg_pkg::ADDR_W-1:0] addr;
  } fetch_req_t;

  // --------------------------------------------------
  // refill port
  // --------------------------------------------------

  // line aligned address, low offset bits are always zero
  typedef struct packed {
    logic [l0_cfg_pkg::ADDR_W-1:0] addr;
  } refill_req_t;

  // full line plus an error flag from the next level
  typedef struct packed {
    logic [l0_cfg_pkg::LINE_W-1:0] data;
    logic                          error;
  } refill_rsp_t;

endpackage

/* rtl/l0_cfg_pkg.sv */
/*
  Geometry constants of the L0 fetch cache: address, instruction word and
  line widths, plus the alignment splits derived from them. The RTL refers
  to these by scoped names.
*/

package l0_cfg_pkg;

  // --------------------------------------------------
  // address and word geometry
  // --------------------------------------------------
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned FETCH_W = 32;
  localparam int unsigned LINE_W  = 128;

  // byte offset bits inside a line and inside a word
  localparam int unsigned LINE_ALIGN  = 4;
  localparam int unsigned FETCH_ALIGN = 2;

  // tag covers everything above the line offset
  localparam int unsigned TAG_W = ADDR_W - LINE_ALIGN;

  // line count used when the top level is not overridden
  localparam int unsigned DEFAULT_LINE_COUNT = 4;

endpackage
